//--- rtl/grid_pkg.sv
`default_nettype none

// Block grid geometry shared by the looper, the slots and the workers
package grid_pkg;

	// Width of one block coordinate
	localparam int WORK_BW = 8;

	// Number of grid dimensions, dimension 0 runs fastest
	localparam int VDIM = 3;

	// One coordinate per dimension
	// d0 sits in the low bits so the array view below lines up
	typedef struct packed {
		logic [WORK_BW-1:0] d2;
		logic [WORK_BW-1:0] d1;
		logic [WORK_BW-1:0] d0;
	} grid_vec_t;

	// Same bits seen as an array, index 0 is d0
	typedef logic [VDIM-1:0][WORK_BW-1:0] grid_arr_t;

	// Start request payload
	typedef struct packed {
		grid_vec_t step;
		grid_vec_t stop;	// exclusive end in every dimension
	} grid_cfg_t;

endpackage

`default_nettype wire

//--- rtl/dispatch_pkg.sv
`default_nettype none

// Control encodings and worker reports for the block looper
package dispatch_pkg;

	// Looper phase
	typedef enum logic [1:0] {
		// Waiting for a start request
		LOOP_IDLE  = 2'd0,
		// Stepper still emitting origins
		LOOP_RUN   = 2'd1,
		// Every origin sent, waiting on the workers
		LOOP_DRAIN = 2'd2
	} looper_state_e;

	// Stepper phase
	typedef enum logic {
		STEP_IDLE = 1'b0,
		STEP_EMIT = 1'b1
	} stepper_state_e;

	// Done report of one worker
	// valid is a one-cycle strobe, origin names the finished block
	typedef struct packed {
		logic                valid;
		grid_pkg::grid_vec_t origin;
	} block_done_t;

endpackage

`default_nettype wire

//--- rtl/grid_offset_stepper.sv
`default_nettype none
`timescale 1ns/100ps

module grid_offset_stepper (
	input  wire                       i_clk,
	input  wire                       i_arst_n,
	input  wire                       i_cfg_rdy,
	output logic                      o_cfg_ack,
	input  wire grid_pkg::grid_cfg_t  i_cfg,
	output logic                      o_ofs_rdy,
	input  wire                       i_ofs_ack,
	output grid_pkg::grid_vec_t       o_ofs
);

	localparam int WBW  = grid_pkg::WORK_BW;
	localparam int VDIM = grid_pkg::VDIM;

	dispatch_pkg::stepper_state_e state_r;
	grid_pkg::grid_arr_t          step_r;
	grid_pkg::grid_arr_t          stop_r;
	grid_pkg::grid_arr_t          ofs_r;
	grid_pkg::grid_arr_t          ofs_nxt;
	logic                         is_last;
	logic                         ofs_acc;

	// =========================================================================
	// Handshakes
	// =========================================================================

	// A new grid is only taken between walks
	assign o_cfg_ack = i_cfg_rdy && (state_r == dispatch_pkg::STEP_IDLE);

	// Origin stays up until the looper takes it
	assign o_ofs_rdy = (state_r == dispatch_pkg::STEP_EMIT);
	assign o_ofs     = grid_pkg::grid_vec_t'(ofs_r);
	assign ofs_acc   = o_ofs_rdy && i_ofs_ack;

	// =========================================================================
	// Next origin in raster order
	// =========================================================================

	// Add the step to dimension 0 first
	// A dimension that would reach its end wraps to zero and carries up
	// Carry out of the top dimension means the current origin is the last one
	always_comb begin
		logic [WBW:0] sum;
		logic         carry;
		ofs_nxt = ofs_r;
		carry   = 1'b1;
		for (int i = 0; i < VDIM; i++) begin
			// One extra bit so a large step cannot wrap past the end
			sum = {1'b0, ofs_r[i]} + {1'b0, step_r[i]};
			if (carry) begin
				if (sum >= {1'b0, stop_r[i]}) begin
					ofs_nxt[i] = '0;
				end else begin
					ofs_nxt[i] = sum[WBW-1:0];
					carry      = 1'b0;
				end
			end
		end
		is_last = carry;
	end

	// Phase
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state_r <= dispatch_pkg::STEP_IDLE;
		end else begin
			case (state_r)
				dispatch_pkg::STEP_IDLE: begin
					if (o_cfg_ack) begin
						state_r <= dispatch_pkg::STEP_EMIT;
					end
				end
				dispatch_pkg::STEP_EMIT: begin
					// Back to idle once the last origin is taken
					if (ofs_acc && is_last) begin
						state_r <= dispatch_pkg::STEP_IDLE;
					end
				end
				default: begin
					state_r <= dispatch_pkg::STEP_IDLE;
				end
			endcase
		end
	end

	// Grid description and running origin
	always_ff @(posedge i_clk) begin
		if (o_cfg_ack) begin
			step_r <= grid_pkg::grid_arr_t'(i_cfg.step);
			stop_r <= grid_pkg::grid_arr_t'(i_cfg.stop);
			// Every walk starts at the grid corner
			ofs_r  <= '0;
		end else if (ofs_acc) begin
			ofs_r <= ofs_nxt;
		end
	end

endmodule

`default_nettype wire

//--- rtl/round_robin_picker.sv
`default_nettype none
`timescale 1ns/100ps

module round_robin_picker #(
	parameter int N_TAU = 4
) (
	input  wire               i_clk,
	input  wire               i_arst_n,
	input  wire  [N_TAU-1:0]  i_free,
	input  wire               i_advance,
	output logic [N_TAU-1:0]  o_pick,
	output logic              o_any
);

	localparam int PTR_BW = (N_TAU > 1) ? $clog2(N_TAU) : 1;

	logic [PTR_BW-1:0]  ptr_r;
	logic [2*N_TAU-1:0] free_dbl;
	logic [N_TAU-1:0]   free_rot;
	logic [N_TAU-1:0]   pick_rot;
	logic [2*N_TAU-1:0] pick_dbl;

	// Rotate so the slot under the pointer lands at bit 0
	assign free_dbl = {2{i_free}} >> ptr_r;
	assign free_rot = free_dbl[N_TAU-1:0];

	// Lowest set bit of the rotated vector wins
	always_comb begin
		logic found;
		found    = 1'b0;
		pick_rot = '0;
		for (int i = 0; i < N_TAU; i++) begin
			if (free_rot[i] && !found) begin
				pick_rot[i] = 1'b1;
				found       = 1'b1;
			end
		end
	end

	// Rotate the one-hot back, upper half holds the real slot index
	assign pick_dbl = {2{pick_rot}} << ptr_r;
	assign o_pick   = pick_dbl[2*N_TAU-1:N_TAU];
	assign o_any    = |i_free;

	// Pointer steps by one per dispatch, wrapping at the last slot
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			ptr_r <= '0;
		end else if (i_advance) begin
			ptr_r <= (ptr_r == PTR_BW'(N_TAU - 1)) ? '0 : ptr_r + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- rtl/worker_slot.sv
`default_nettype none
`timescale 1ns/100ps

module worker_slot #(
	parameter int N_PENDING = 2
) (
	input  wire                       i_clk,
	input  wire                       i_arst_n,
	input  wire                       i_load,
	input  wire grid_pkg::grid_vec_t  i_ofs,
	output logic                      o_free,
	output logic                      o_bofs_rdy,
	input  wire                       i_bofs_ack,
	output grid_pkg::grid_vec_t       o_bofs,
	input  wire                       i_done,
	output logic                      o_empty
);

	localparam int CNT_BW = $clog2(N_PENDING + 1);

	// Forward register holds an origin
	logic              fwd_vld_r;
	// Blocks sent to the worker and not reported done yet
	logic [CNT_BW-1:0] pend_r;
	logic              can_send;
	logic              bofs_acc;

	assign can_send   = (pend_r < CNT_BW'(N_PENDING));
	// Looper may load only into an empty forward register
	assign o_free     = !fwd_vld_r;
	// Held back while the worker already has its limit
	assign o_bofs_rdy = fwd_vld_r && can_send;
	assign o_empty    = (pend_r == '0);
	assign bofs_acc   = o_bofs_rdy && i_bofs_ack;

	// Forward register valid
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			fwd_vld_r <= 1'b0;
		end else if (i_load) begin
			fwd_vld_r <= 1'b1;
		end else if (bofs_acc) begin
			fwd_vld_r <= 1'b0;
		end
	end

	// Pending counter, up on send and down on done
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			pend_r <= '0;
		end else begin
			case ({bofs_acc, i_done})
				2'b10:   pend_r <= pend_r + 1'b1;
				2'b01:   pend_r <= pend_r - 1'b1;
				default: pend_r <= pend_r;
			endcase
		end
	end

	// Origin register
	always_ff @(posedge i_clk) begin
		if (i_load) begin
			o_bofs <= i_ofs;
		end
	end

endmodule

`default_nettype wire

//--- rtl/block_looper.sv
`default_nettype none
`timescale 1ns/100ps

module block_looper #(
	parameter int N_TAU     = 4,
	parameter int N_PENDING = 2
) (
	input  wire                             i_clk,
	input  wire                             i_arst_n,
	input  wire                             i_start_rdy,
	output logic                            o_start_ack,
	input  wire grid_pkg::grid_cfg_t        i_start_cfg,
	output logic [N_TAU-1:0]                o_bofs_rdys,
	input  wire  [N_TAU-1:0]                i_bofs_acks,
	output grid_pkg::grid_vec_t             o_bofss [N_TAU],
	input  wire dispatch_pkg::block_done_t  i_dones [N_TAU]
);

	dispatch_pkg::looper_state_e state_r;
	logic                        step_cfg_rdy;
	logic                        step_cfg_ack;
	logic                        ofs_rdy;
	logic                        ofs_ack;
	grid_pkg::grid_vec_t         ofs;
	logic [N_TAU-1:0]            slot_free;
	logic [N_TAU-1:0]            slot_empty;
	logic [N_TAU-1:0]            slot_load;
	logic [N_TAU-1:0]            slot_done;
	logic [N_TAU-1:0]            pick;
	logic                        pick_any;
	logic                        wait_fin_rdy;
	logic                        wait_fin_ack;

	// =========================================================================
	// Start split, stepper branch first and wait-finish branch second
	// =========================================================================

	assign step_cfg_rdy = i_start_rdy && (state_r == dispatch_pkg::LOOP_IDLE);
	assign wait_fin_rdy = i_start_rdy && (state_r == dispatch_pkg::LOOP_DRAIN);

	// Nothing left in any slot and no slot still offering an origin
	assign wait_fin_ack = wait_fin_rdy && (&slot_empty) && !(|o_bofs_rdys);
	assign o_start_ack  = wait_fin_ack;

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state_r <= dispatch_pkg::LOOP_IDLE;
		end else begin
			case (state_r)
				dispatch_pkg::LOOP_IDLE: begin
					if (step_cfg_ack) begin
						state_r <= dispatch_pkg::LOOP_RUN;
					end
				end
				dispatch_pkg::LOOP_RUN: begin
					// Stepper dropped its ready, so the last origin is in a slot
					if (!ofs_rdy) begin
						state_r <= dispatch_pkg::LOOP_DRAIN;
					end
				end
				dispatch_pkg::LOOP_DRAIN: begin
					if (wait_fin_ack) begin
						state_r <= dispatch_pkg::LOOP_IDLE;
					end
				end
				default: begin
					state_r <= dispatch_pkg::LOOP_IDLE;
				end
			endcase
		end
	end

	// =========================================================================
	// Stepper and dispatch
	// =========================================================================

	grid_offset_stepper u_stepper (
		.i_clk     (i_clk),
		.i_arst_n  (i_arst_n),
		.i_cfg_rdy (step_cfg_rdy),
		.o_cfg_ack (step_cfg_ack),
		.i_cfg     (i_start_cfg),
		.o_ofs_rdy (ofs_rdy),
		.i_ofs_ack (ofs_ack),
		.o_ofs     (ofs)
	);

	// Take the origin only when some forward register is free
	assign ofs_ack   = ofs_rdy && pick_any;
	assign slot_load = pick & {N_TAU{ofs_ack}};

	round_robin_picker #(
		.N_TAU (N_TAU)
	) u_picker (
		.i_clk     (i_clk),
		.i_arst_n  (i_arst_n),
		.i_free    (slot_free),
		.i_advance (ofs_ack),
		.o_pick    (pick),
		.o_any     (pick_any)
	);

	// One slot in front of every worker
	for (genvar i = 0; i < N_TAU; i++) begin : g_slot
		assign slot_done[i] = i_dones[i].valid;

		worker_slot #(
			.N_PENDING (N_PENDING)
		) u_slot (
			.i_clk      (i_clk),
			.i_arst_n   (i_arst_n),
			.i_load     (slot_load[i]),
			.i_ofs      (ofs),
			.o_free     (slot_free[i]),
			.o_bofs_rdy (o_bofs_rdys[i]),
			.i_bofs_ack (i_bofs_acks[i]),
			.o_bofs     (o_bofss[i]),
			.i_done     (slot_done[i]),
			.o_empty    (slot_empty[i])
		);
	end

endmodule

`default_nettype wire

//--- rtl/block_worker.sv
`default_nettype none
`timescale 1ns/100ps

module block_worker #(
	parameter int N_PENDING = 2
) (
	input  wire                        i_clk,
	input  wire                        i_arst_n,
	input  wire                        i_bofs_rdy,
	output logic                       o_bofs_ack,
	input  wire grid_pkg::grid_vec_t   i_bofs,
	output dispatch_pkg::block_done_t  o_done
);

	localparam int PTR_BW = (N_PENDING > 1) ? $clog2(N_PENDING) : 1;
	localparam int CNT_BW = $clog2(N_PENDING + 1);

	// Origin queue
	grid_pkg::grid_vec_t fifo_mem [N_PENDING];
	logic [PTR_BW-1:0]   wr_ptr_r;
	logic [PTR_BW-1:0]   rd_ptr_r;
	logic [CNT_BW-1:0]   fill_r;
	logic                push;
	logic                pop;
	grid_pkg::grid_vec_t head;

	// Block in progress
	logic                busy_r;
	logic [3:0]          rem_r;
	logic [2:0]          lat_sum;
	logic                finishing;
	grid_pkg::grid_vec_t cur_r;

	function automatic logic [PTR_BW-1:0] ptr_inc(input logic [PTR_BW-1:0] p);
		return (p == PTR_BW'(N_PENDING - 1)) ? '0 : p + 1'b1;
	endfunction

	assign o_bofs_ack = i_bofs_rdy && (fill_r != CNT_BW'(N_PENDING));
	assign push       = o_bofs_ack;
	assign head       = fifo_mem[rd_ptr_r];

	// Last busy cycle, the next block may start right behind it
	assign finishing  = busy_r && (rem_r == 4'd1);
	assign pop        = (fill_r != '0) && (!busy_r || finishing);

	// Latency is 2 plus the low three bits of the coordinate sum
	assign lat_sum    = head.d0[2:0] + head.d1[2:0] + head.d2[2:0];

	assign o_done = '{valid: finishing, origin: cur_r};

	// Queue pointers and fill level
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wr_ptr_r <= '0;
			rd_ptr_r <= '0;
			fill_r   <= '0;
		end else begin
			if (push) begin
				wr_ptr_r <= ptr_inc(wr_ptr_r);
			end
			if (pop) begin
				rd_ptr_r <= ptr_inc(rd_ptr_r);
			end
			case ({push, pop})
				2'b10:   fill_r <= fill_r + 1'b1;
				2'b01:   fill_r <= fill_r - 1'b1;
				default: fill_r <= fill_r;
			endcase
		end
	end

	// Busy countdown
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			busy_r <= 1'b0;
			rem_r  <= '0;
		end else if (pop) begin
			busy_r <= 1'b1;
			rem_r  <= {1'b0, lat_sum} + 4'd2;
		end else if (busy_r) begin
			busy_r <= !finishing;
			rem_r  <= rem_r - 1'b1;
		end
	end

	// Queue storage and current origin
	always_ff @(posedge i_clk) begin
		if (push) begin
			fifo_mem[wr_ptr_r] <= i_bofs;
		end
		if (pop) begin
			cur_r <= head;
		end
	end

endmodule

`default_nettype wire

//--- rtl/block_looper_top.sv
`default_nettype none
`timescale 1ns/100ps

module block_looper_top #(
	parameter int N_TAU     = 4,
	parameter int N_PENDING = 2
) (
	input  wire                        i_clk,
	input  wire                        i_arst_n,
	input  wire                        i_start_rdy,
	output logic                       o_start_ack,
	input  wire grid_pkg::grid_cfg_t   i_start_cfg,
	output dispatch_pkg::block_done_t  o_done [N_TAU]
);

	// Slot to worker handshake
	logic [N_TAU-1:0]    bofs_rdys;
	logic [N_TAU-1:0]    bofs_acks;
	grid_pkg::grid_vec_t bofss [N_TAU];

	// Done reports go to the looper and straight out for observation
	block_looper #(
		.N_TAU     (N_TAU),
		.N_PENDING (N_PENDING)
	) u_looper (
		.i_clk       (i_clk),
		.i_arst_n    (i_arst_n),
		.i_start_rdy (i_start_rdy),
		.o_start_ack (o_start_ack),
		.i_start_cfg (i_start_cfg),
		.o_bofs_rdys (bofs_rdys),
		.i_bofs_acks (bofs_acks),
		.o_bofss     (bofss),
		.i_dones     (o_done)
	);

	for (genvar i = 0; i < N_TAU; i++) begin : g_worker
		block_worker #(
			.N_PENDING (N_PENDING)
		) u_worker (
			.i_clk      (i_clk),
			.i_arst_n   (i_arst_n),
			.i_bofs_rdy (bofs_rdys[i]),
			.o_bofs_ack (bofs_acks[i]),
			.i_bofs     (bofss[i]),
			.o_done     (o_done[i])
		);
	end

endmodule

`default_nettype wire

//--- testbench/block_looper_assertions.sv
`default_nettype none
`timescale 1ns/100ps

module block_looper_assertions #(
	parameter int N_TAU     = 4,
	parameter int N_PENDING = 2
) (
	input wire                             i_clk,
	input wire                             i_arst_n,
	input wire                             i_start_rdy,
	input wire                             i_start_ack,
	input wire                             i_ofs_rdy,
	input wire                             i_ofs_ack,
	input wire  [N_TAU-1:0]                i_bofs_rdys,
	input wire  [N_TAU-1:0]                i_bofs_acks,
	input wire dispatch_pkg::block_done_t  i_dones [N_TAU]
);

	// Blocks outstanding per worker, rebuilt from the handshakes
	int   pend [N_TAU];
	// No worker holds a block according to that count
	logic all_drained;

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int i = 0; i < N_TAU; i++) begin
				pend[i] <= 0;
			end
		end else begin
			for (int i = 0; i < N_TAU; i++) begin
				pend[i] <= pend[i] + 32'(i_bofs_rdys[i] && i_bofs_acks[i])
					- 32'(i_dones[i].valid);
			end
		end
	end

	always_comb begin
		all_drained = 1'b1;
		for (int i = 0; i < N_TAU; i++) begin
			if (pend[i] != 0) begin
				all_drained = 1'b0;
			end
		end
	end

	// Start request and origin stay up until taken
	a_start_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_start_rdy && !i_start_ack |=> i_start_rdy)
		else $error("start ready dropped before its acknowledge");

	a_ofs_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_ofs_rdy && !i_ofs_ack |=> i_ofs_rdy)
		else $error("stepper origin ready dropped before its acknowledge");

	for (genvar i = 0; i < N_TAU; i++) begin : g_slot_chk
		a_slot_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
			i_bofs_rdys[i] && !i_bofs_acks[i] |=> i_bofs_rdys[i])
			else $error("slot %0d ready dropped before its acknowledge", i);

		a_pend_limit: assert property (@(posedge i_clk) disable iff (!i_arst_n)
			pend[i] <= N_PENDING)
			else $error("slot %0d has more than %0d blocks outstanding", i, N_PENDING);
	end

	// Whole grid finished before the start is answered
	a_ack_empty: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_start_ack |-> all_drained)
		else $error("start acknowledged while a slot still has blocks");

endmodule

bind block_looper block_looper_assertions #(
	.N_TAU     (N_TAU),
	.N_PENDING (N_PENDING)
) u_assertions (
	.i_clk        (i_clk),
	.i_arst_n     (i_arst_n),
	.i_start_rdy  (i_start_rdy),
	.i_start_ack  (o_start_ack),
	.i_ofs_rdy    (ofs_rdy),
	.i_ofs_ack    (ofs_ack),
	.i_bofs_rdys  (o_bofs_rdys),
	.i_bofs_acks  (i_bofs_acks),
	.i_dones      (i_dones)
);

`default_nettype wire

//--- testbench/tb_block_looper.sv
`default_nettype none
`timescale 1ns/100ps

module tb_block_looper;

	localparam int N_TAU     = 4;
	localparam int N_PENDING = 2;
	localparam int WBW       = grid_pkg::WORK_BW;
	localparam int VBW       = $bits(grid_pkg::grid_vec_t);

	logic                      clk;
	logic                      arst_n;
	logic                      start_rdy;
	logic                      start_ack;
	grid_pkg::grid_cfg_t       start_cfg;
	dispatch_pkg::block_done_t done_rpt [N_TAU];

	// Model and scoreboard state
	grid_pkg::grid_vec_t exp_q [$];
	grid_pkg::grid_vec_t got_q [$];
	int                  done_cnt = 0;
	int                  order_err = 0;
	int                  grid_no = 0;
	int                  last_grid [N_TAU];
	int unsigned         last_key [N_TAU];
	int                  base_cnt;
	int                  base_ord;
	int                  pass_cnt = 0;
	int                  fail_cnt = 0;
	int                  seed = 70;
	logic                timed_out = 1'b0;
	logic                have_prev = 1'b0;
	string               last_name;
	int                  last_ack_cnt;

	block_looper_top #(
		.N_TAU     (N_TAU),
		.N_PENDING (N_PENDING)
	) u_dut (
		.i_clk       (clk),
		.i_arst_n    (arst_n),
		.i_start_rdy (start_rdy),
		.o_start_ack (start_ack),
		.i_start_cfg (start_cfg),
		.o_done      (done_rpt)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ========================================================================
	// Helpers
	// ========================================================================

	// Packed origin as a number, raster order since d2 sits on top
	function automatic int unsigned key_of(input grid_pkg::grid_vec_t v);
		return {8'd0, v};
	endfunction

	function automatic grid_pkg::grid_vec_t vec_of(input int unsigned k);
		return grid_pkg::grid_vec_t'(k[VBW-1:0]);
	endfunction

	function automatic grid_pkg::grid_vec_t make_vec(input int a0, input int a1, input int a2);
		grid_pkg::grid_vec_t v;
		v.d0 = WBW'(a0);
		v.d1 = WBW'(a1);
		v.d2 = WBW'(a2);
		return v;
	endfunction

	task automatic random_cfg(output grid_pkg::grid_cfg_t cfg);
		int r [6];
		for (int k = 0; k < 6; k++) begin
			r[k] = $random(seed);
			r[k] = r[k] & 32'h7fff_ffff;
		end
		// Steps 1 to 7, ends 1 to 20
		cfg.step = make_vec(1 + r[0] % 7, 1 + r[1] % 7, 1 + r[2] % 7);
		cfg.stop = make_vec(1 + r[3] % 20, 1 + r[4] % 20, 1 + r[5] % 20);
	endtask

	// Every origin of the grid, dimension 0 fastest
	task automatic build_model(input grid_pkg::grid_cfg_t cfg);
		exp_q.delete();
		for (int z = 0; z < 32'(cfg.stop.d2); z += 32'(cfg.step.d2)) begin
			for (int y = 0; y < 32'(cfg.stop.d1); y += 32'(cfg.step.d1)) begin
				for (int x = 0; x < 32'(cfg.stop.d0); x += 32'(cfg.step.d0)) begin
					exp_q.push_back(make_vec(x, y, z));
				end
			end
		end
	endtask

	// ========================================================================
	// Done monitor
	// ========================================================================

	// Sampled on the falling edge, away from the register updates
	always @(negedge clk) begin
		for (int i = 0; i < N_TAU; i++) begin
			if (done_rpt[i].valid === 1'b1) begin
				done_cnt++;
				got_q.push_back(done_rpt[i].origin);
				// FIFO per worker keeps raster order within one grid
				if (last_grid[i] == grid_no && key_of(done_rpt[i].origin) <= last_key[i]) begin
					order_err++;
				end
				last_key[i]  = key_of(done_rpt[i].origin);
				last_grid[i] = grid_no;
			end
		end
	end

	// ========================================================================
	// Compare tasks
	// ========================================================================

	task automatic check_count(input string name, input int exp, input int act);
		if (exp == act) begin
			pass_cnt++;
			$display("[PASS] %s: %0d", name, act);
		end else begin
			fail_cnt++;
			$display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	task automatic check_origin(input string name, input grid_pkg::grid_vec_t exp,
		input grid_pkg::grid_vec_t act);
		if (exp == act) begin
			pass_cnt++;
			$display("[PASS] %s", name);
		end else begin
			fail_cnt++;
			$display("[FAIL] %s: expected (%0d,%0d,%0d), actual (%0d,%0d,%0d)", name,
				exp.d0, exp.d1, exp.d2, act.d0, act.d1, act.d2);
		end
	endtask

	// Done origins of this grid against the model, duplicates and gaps included
	task automatic check_set(input string name);
		int                  hits [int unsigned];
		grid_pkg::grid_vec_t sorted_q [$];
		int unsigned         k;
		int                  idx;
		for (int j = base_cnt; j < done_cnt; j++) begin
			k = key_of(got_q[j]);
			if (hits.exists(k)) begin
				hits[k] = hits[k] + 1;
			end else begin
				hits[k] = 1;
			end
		end
		// Ascending key walk rebuilds raster order
		foreach (hits[key]) begin
			for (int r = 0; r < hits[key]; r++) begin
				sorted_q.push_back(vec_of(key));
			end
		end
		if (sorted_q.size() != exp_q.size()) begin
			check_count({name, " origin total"}, exp_q.size(), sorted_q.size());
		end else begin
			idx = 0;
			while (idx < exp_q.size() - 1 && sorted_q[idx] == exp_q[idx]) begin
				idx++;
			end
			check_origin({name, " origins"}, exp_q[idx], sorted_q[idx]);
		end
	endtask

	// Nothing may finish between an acknowledge and the next start
	task automatic check_quiet();
		if (have_prev) begin
			check_count({last_name, " done after ack"}, last_ack_cnt, done_cnt);
		end
	endtask

	// ========================================================================
	// Waits, each bounded in cycles
	// ========================================================================

	task automatic wait_first_done(input string name, input int limit);
		int cycles;
		cycles = 0;
		while (done_cnt == base_cnt && !timed_out) begin
			@(negedge clk);
			// Let the done monitor count this edge first
			#1;
			cycles++;
			if (cycles >= limit && done_cnt == base_cnt) begin
				$display("Timeout: no block of %s finished within %0d cycles", name, limit);
				fail_cnt++;
				timed_out = 1'b1;
			end
		end
	endtask

	task automatic wait_start_ack(input string name, input int limit);
		int cycles;
		cycles = 0;
		while (!start_ack && !timed_out) begin
			@(negedge clk);
			cycles++;
			if (cycles >= limit && !start_ack) begin
				$display("Timeout: start of %s not acknowledged within %0d cycles", name, limit);
				fail_cnt++;
				timed_out = 1'b1;
			end
		end
	endtask

	// One grid from start request to acknowledge, then its checks
	task automatic run_grid(input string name, input grid_pkg::grid_cfg_t cfg);
		int limit;
		build_model(cfg);
		grid_no++;
		base_cnt  = done_cnt;
		base_ord  = order_err;
		limit     = 20 * exp_q.size() + 200;
		start_cfg = cfg;
		start_rdy = 1'b1;
		// Previous grid stays silent while this start waits to be taken
		@(negedge clk);
		#1;
		check_quiet();
		wait_first_done(name, limit);
		wait_start_ack(name, limit);
		if (timed_out) begin
			return;
		end
		// Transfer on the acknowledged edge
		@(posedge clk);
		#2;
		start_rdy = 1'b0;
		check_count({name, " done count at ack"}, exp_q.size(), done_cnt - base_cnt);
		check_set(name);
		check_count({name, " worker order errors"}, 0, order_err - base_ord);
		last_name    = name;
		last_ack_cnt = done_cnt;
		have_prev    = 1'b1;
	endtask

	task automatic run_all();
		grid_pkg::grid_cfg_t cfg;
		// Step past the end everywhere, a single block at zero
		cfg.step = make_vec(4, 4, 4);
		cfg.stop = make_vec(3, 3, 3);
		run_grid("single block", cfg);
		if (timed_out) begin
			return;
		end
		// Back to back random grids
		for (int g = 0; g < 10; g++) begin
			random_cfg(cfg);
			run_grid($sformatf("grid %0d", g), cfg);
			if (timed_out) begin
				return;
			end
		end
	endtask

	// ========================================================================
	// Main sequence
	// ========================================================================

	initial begin
		for (int i = 0; i < N_TAU; i++) begin
			last_grid[i] = -1;
			last_key[i]  = 0;
		end
		arst_n    = 1'b0;
		start_rdy = 1'b0;
		start_cfg = '0;
		repeat (5) @(posedge clk);
		#2;
		arst_n = 1'b1;
		@(posedge clk);
		#2;
		run_all();
		if (!timed_out) begin
			// Idle tail after the last grid
			repeat (20) @(posedge clk);
			#2;
			check_quiet();
		end
		$display("Checks passed %0d, failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0 && !timed_out) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- block_looper.f
rtl/grid_pkg.sv
rtl/dispatch_pkg.sv
rtl/grid_offset_stepper.sv
rtl/round_robin_picker.sv
rtl/worker_slot.sv
rtl/block_looper.sv
rtl/block_worker.sv
rtl/block_looper_top.sv
testbench/block_looper_assertions.sv
testbench/tb_block_looper.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the block looper testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module tb_block_looper \
	-Mdir obj_dir \
	-f block_looper.f

# An assertion stop ends the run early, the printed result decides
sim_out=$(./obj_dir/Vtb_block_looper) || true
echo "$sim_out"

if echo "$sim_out" | grep -qx "Test OK"; then
	exit 0
fi
exit 1
